// File: src/nonogram_pkg.sv
`default_nettype none

package nonogram_pkg;

    ////////////////////////////////////////
    // pixel format
    ////////////////////////////////////////

    // rgb 4:4:4, one pixel per grid cell
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    ////////////////////////////////////////
    // grid and clue format
    ////////////////////////////////////////

    localparam int default_grid_w = 40;  // cells per row
    localparam int default_grid_h = 30;  // cells per column

    localparam int run_w = 6;  // bits per run field

    // luma sum at or below this is a black cell
    localparam logic [3:0] fill_threshold = 4'd5;

    // worst case is alternating filled and empty cells
    function automatic int max_runs(input int length);
        return (length + 1) / 2;
    endfunction

endpackage

`default_nettype wire

// File: src/cell_binarizer.sv
`timescale 1ns/1ps
`default_nettype none

module cell_binarizer (
    input  wire logic                 clk_65mhz,
    input  wire logic                 reset,
    // pixel stream in
    input  wire logic                 pixel_valid,
    output logic                      pixel_ready,
    input  wire nonogram_pkg::pixel_t pixel_data,
    // cell stream out
    output logic                      cell_valid,
    input  wire logic                 cell_ready,
    output logic                      cell_filled
);
    import nonogram_pkg::*;

    logic [3:0] luma;  // max 3 + 7 + 3 = 13, fits
    logic       take;

    // weighted luma, green counts double
    assign luma = (pixel_data.red >> 2) + (pixel_data.green >> 1) + (pixel_data.blue >> 2);

    // slot empty or draining this cycle
    assign pixel_ready = !cell_valid || cell_ready;
    assign take        = pixel_valid && pixel_ready;

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            cell_valid <= 1'b0;
        end else if (pixel_ready) begin
            cell_valid <= pixel_valid;
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (take) begin
            cell_filled <= (luma <= fill_threshold);  // dark pixel -> filled cell
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // buffer side may stall, the cell must wait unchanged
    cell_hold: assert property (@(posedge clk_65mhz) disable iff (reset)
        cell_valid && !cell_ready |=> cell_valid && $stable(cell_filled));

endmodule

`default_nettype wire

// File: src/grid_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module grid_frame_buffer #(
    parameter  int grid_w   = nonogram_pkg::default_grid_w,
    parameter  int grid_h   = nonogram_pkg::default_grid_h,
    localparam int row_bits = $clog2(grid_h),
    localparam int col_bits = $clog2(grid_w)
) (
    input  wire logic                clk_65mhz,
    input  wire logic                reset,
    // cell stream in, raster order
    input  wire logic                cell_valid,
    output logic                     cell_ready,
    input  wire logic                cell_filled,
    // frame link to the encoder
    output logic                     frame_valid,
    input  wire logic [row_bits-1:0] rd_row,
    input  wire logic [col_bits-1:0] rd_col,
    output logic                     rd_filled,
    input  wire logic                frame_done
);

    logic [grid_w-1:0]   cells [grid_h];  // one bit per cell, 1 = black
    logic [row_bits-1:0] wr_row;
    logic [col_bits-1:0] wr_col;
    logic                full;
    logic                wr_en;
    logic                last_col;
    logic                last_cell;

    assign cell_ready  = !full;
    assign frame_valid = full;
    assign wr_en       = cell_valid && cell_ready;

    assign last_col  = (wr_col == col_bits'(grid_w - 1));
    assign last_cell = last_col && (wr_row == row_bits'(grid_h - 1));

    // encoder reads straight out of the array
    assign rd_filled = cells[rd_row][rd_col];

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            wr_row <= '0;
            wr_col <= '0;
            full   <= 1'b0;
        end else begin
            if (wr_en) begin
                if (last_col) begin
                    wr_col <= '0;
                    // wraps to the top on the last cell
                    wr_row <= last_cell ? '0 : wr_row + 1'b1;
                end else begin
                    wr_col <= wr_col + 1'b1;
                end
            end

            if (frame_done) begin
                full <= 1'b0;  // encoder finished, accept the next frame
            end else if (wr_en && last_cell) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (wr_en) begin
            cells[wr_row][wr_col] <= cell_filled;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // while full nothing lands and the pointer sits at cell 0
    no_write_when_full: assert property (@(posedge clk_65mhz) disable iff (reset)
        full |-> !wr_en && wr_row == '0 && wr_col == '0);

    // encoder may only release a frame it was given
    done_needs_frame: assert property (@(posedge clk_65mhz) disable iff (reset)
        frame_done |-> frame_valid);

endmodule

`default_nettype wire

// File: src/clue_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module clue_encoder #(
    parameter  int grid_w     = nonogram_pkg::default_grid_w,
    parameter  int grid_h     = nonogram_pkg::default_grid_h,
    localparam int max_dim    = (grid_w > grid_h) ? grid_w : grid_h,
    localparam int slots      = nonogram_pkg::max_runs(max_dim),
    localparam int clue_w     = slots * nonogram_pkg::run_w,
    localparam int runs_bits  = $clog2(slots + 1),
    localparam int index_bits = $clog2(max_dim),
    localparam int row_bits   = $clog2(grid_h),
    localparam int col_bits   = $clog2(grid_w)
) (
    input  wire logic          clk_65mhz,
    input  wire logic          reset,
    // frame link from the buffer
    input  wire logic          frame_valid,
    output logic [row_bits-1:0] rd_row,
    output logic [col_bits-1:0] rd_col,
    input  wire logic          rd_filled,
    output logic               frame_done,
    // clue stream out
    output logic               clue_valid,
    input  wire logic          clue_ready,
    output logic [clue_w-1:0]  clue_data,
    output logic [runs_bits-1:0] clue_runs,
    output logic               clue_is_column,
    output logic [index_bits-1:0] clue_index
);
    import nonogram_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_scan_rows,
        st_scan_cols,
        st_emit,
        st_done
    } state_t;

    state_t                state;
    logic [index_bits-1:0] pos;          // cell position along the line
    logic                  run_started;
    logic [run_w-1:0]      run_len;
    logic                  scanning;
    logic                  line_end;
    logic                  close_run;
    logic [run_w-1:0]      next_len;
    logic [run_w-1:0]      close_len;
    logic [index_bits-1:0] last_pos;
    logic [index_bits-1:0] last_line;

    ////////////////////////////////////////
    // run tracking
    ////////////////////////////////////////

    assign scanning  = (state == st_scan_rows) || (state == st_scan_cols);
    assign last_pos  = clue_is_column ? index_bits'(grid_h - 1) : index_bits'(grid_w - 1);
    assign last_line = clue_is_column ? index_bits'(grid_w - 1) : index_bits'(grid_h - 1);
    assign line_end  = (pos == last_pos);

    assign next_len = run_started ? run_len + 1'b1 : run_w'(1);

    // a run ends on an empty cell, or with the line if still filled
    assign close_run = scanning && ((!rd_filled && run_started) || (line_end && rd_filled));
    assign close_len = rd_filled ? next_len : run_len;

    // rows walk columns, columns walk rows
    assign rd_row = clue_is_column ? row_bits'(pos) : row_bits'(clue_index);
    assign rd_col = clue_is_column ? col_bits'(clue_index) : col_bits'(pos);

    assign clue_valid = (state == st_emit);
    assign frame_done = (state == st_done);

    ////////////////////////////////////////
    // scan fsm
    ////////////////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            state          <= st_idle;
            pos            <= '0;
            clue_index     <= '0;
            clue_is_column <= 1'b0;
            run_started    <= 1'b0;
            clue_runs      <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (frame_valid) begin
                        state          <= st_scan_rows;
                        pos            <= '0;
                        clue_index     <= '0;
                        clue_is_column <= 1'b0;
                        run_started    <= 1'b0;
                        clue_runs      <= '0;
                    end
                end

                st_scan_rows, st_scan_cols: begin
                    run_started <= rd_filled;
                    if (close_run) begin
                        clue_runs <= clue_runs + 1'b1;
                    end
                    if (line_end) begin
                        pos         <= '0;
                        run_started <= 1'b0;
                        state       <= st_emit;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end

                st_emit: begin
                    // hold everything until the clue is taken
                    if (clue_ready) begin
                        clue_runs <= '0;
                        if (clue_index == last_line) begin
                            clue_index <= '0;
                            if (clue_is_column) begin
                                state <= st_done;
                            end else begin
                                clue_is_column <= 1'b1;  // rows done, on to columns
                                state          <= st_scan_cols;
                            end
                        end else begin
                            clue_index <= clue_index + 1'b1;
                            state      <= clue_is_column ? st_scan_cols : st_scan_rows;
                        end
                    end
                end

                st_done: begin
                    state <= st_idle;  // frame_done is high for this one cycle
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // clue word and run length
    always_ff @(posedge clk_65mhz) begin
        if (scanning) begin
            run_len <= rd_filled ? next_len : '0;
            if (close_run) begin
                clue_data[clue_runs * run_w +: run_w] <= close_len;
            end
        end else if ((state == st_idle) || (clue_valid && clue_ready)) begin
            clue_data <= '0;  // unused fields read as zero
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    clue_stall_hold: assert property (@(posedge clk_65mhz) disable iff (reset)
        clue_valid && !clue_ready |=> clue_valid && $stable(clue_data)
            && $stable(clue_runs) && $stable(clue_index));

endmodule

`default_nettype wire

// File: src/nonogram_clue_top.sv
`timescale 1ns/1ps
`default_nettype none

module nonogram_clue_top #(
    parameter  int grid_w     = nonogram_pkg::default_grid_w,
    parameter  int grid_h     = nonogram_pkg::default_grid_h,
    localparam int max_dim    = (grid_w > grid_h) ? grid_w : grid_h,
    localparam int slots      = nonogram_pkg::max_runs(max_dim),
    localparam int clue_w     = slots * nonogram_pkg::run_w,
    localparam int runs_bits  = $clog2(slots + 1),
    localparam int index_bits = $clog2(max_dim)
) (
    input  wire logic                 clk_65mhz,
    input  wire logic                 reset,
    input  wire logic                 pixel_valid,
    output logic                      pixel_ready,
    input  wire nonogram_pkg::pixel_t pixel_data,
    output logic                      clue_valid,
    input  wire logic                 clue_ready,
    output logic [clue_w-1:0]         clue_data,
    output logic [runs_bits-1:0]      clue_runs,
    output logic                      clue_is_column,
    output logic [index_bits-1:0]     clue_index
);

    localparam int row_bits = $clog2(grid_h);
    localparam int col_bits = $clog2(grid_w);

    logic                cell_valid;
    logic                cell_ready;
    logic                cell_filled;
    logic                frame_valid;
    logic [row_bits-1:0] rd_row;
    logic [col_bits-1:0] rd_col;
    logic                rd_filled;
    logic                frame_done;

    cell_binarizer cell_binarizer_i (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel_data  (pixel_data),
        .cell_valid  (cell_valid),
        .cell_ready  (cell_ready),
        .cell_filled (cell_filled)
    );

    grid_frame_buffer #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) grid_frame_buffer_i (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .cell_valid  (cell_valid),
        .cell_ready  (cell_ready),
        .cell_filled (cell_filled),
        .frame_valid (frame_valid),
        .rd_row      (rd_row),
        .rd_col      (rd_col),
        .rd_filled   (rd_filled),
        .frame_done  (frame_done)
    );

    clue_encoder #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) clue_encoder_i (
        .clk_65mhz      (clk_65mhz),
        .reset          (reset),
        .frame_valid    (frame_valid),
        .rd_row         (rd_row),
        .rd_col         (rd_col),
        .rd_filled      (rd_filled),
        .frame_done     (frame_done),
        .clue_valid     (clue_valid),
        .clue_ready     (clue_ready),
        .clue_data      (clue_data),
        .clue_runs      (clue_runs),
        .clue_is_column (clue_is_column),
        .clue_index     (clue_index)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 8
) (
    output logic clk_65mhz,
    output logic reset
);

    initial begin
        clk_65mhz = 1'b0;
        reset     = 1'b1;
        repeat (reset_cycles) @(posedge clk_65mhz);
        @(negedge clk_65mhz);
        reset = 1'b0;  // released on a falling edge
    end

    always #(period_ns / 2) clk_65mhz = ~clk_65mhz;

endmodule

`default_nettype wire

// File: testbench/nonogram_clue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nonogram_clue_tb;
    import nonogram_pkg::*;

    localparam int grid_w        = default_grid_w;
    localparam int grid_h        = default_grid_h;
    localparam int max_dim       = (grid_w > grid_h) ? grid_w : grid_h;
    localparam int slots         = max_runs(max_dim);
    localparam int clue_w        = slots * run_w;
    localparam int runs_bits     = $clog2(slots + 1);
    localparam int index_bits    = $clog2(max_dim);
    localparam int cells         = grid_w * grid_h;
    localparam int frames        = 5;  // bright, black, then three random
    localparam int total_cells   = frames * cells;
    localparam int timeout_limit =
        4 * frames * (cells + (grid_h + 1) * grid_w + (grid_w + 1) * grid_h);

    logic                  clk_65mhz;
    logic                  reset;
    logic                  pixel_valid;
    logic                  pixel_ready;
    pixel_t                pixel_data;
    logic                  clue_valid;
    logic                  clue_ready;
    logic [clue_w-1:0]     clue_data;
    logic [runs_bits-1:0]  clue_runs;
    logic                  clue_is_column;
    logic [index_bits-1:0] clue_index;

    logic [15:0]           lfsr = 16'd23133;
    pixel_t                pix_mem [total_cells];
    logic [grid_w-1:0]     model_grid [grid_h];
    int                    pix_idx = 0;
    logic                  pix_taken = 1'b0;
    int                    cycle_count = 0;

    // expected clues, rows then columns, frame after frame
    logic [clue_w-1:0]     exp_data_q [$];
    logic [runs_bits-1:0]  exp_runs_q [$];
    logic                  exp_col_q [$];
    logic [index_bits-1:0] exp_idx_q [$];

    tb_clock_gen clock_gen_i (
        .clk_65mhz (clk_65mhz),
        .reset     (reset)
    );

    nonogram_clue_top #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) nonogram_clue_top_i (
        .clk_65mhz      (clk_65mhz),
        .reset          (reset),
        .pixel_valid    (pixel_valid),
        .pixel_ready    (pixel_ready),
        .pixel_data     (pixel_data),
        .clue_valid     (clue_valid),
        .clue_ready     (clue_ready),
        .clue_data      (clue_data),
        .clue_runs      (clue_runs),
        .clue_is_column (clue_is_column),
        .clue_index     (clue_index)
    );

    ////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;  // taps 16,14,13,11
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic is_dark(input pixel_t p);
        int luma;
        luma = int'(p.red >> 2) + int'(p.green >> 1) + int'(p.blue >> 2);
        return luma <= int'(fill_threshold);
    endfunction

    task automatic push_expected(input logic [clue_w-1:0] word, input int runs,
                                 input logic is_col, input int idx);
        exp_data_q.push_back(word);
        exp_runs_q.push_back(runs_bits'(runs));
        exp_col_q.push_back(is_col);
        exp_idx_q.push_back(index_bits'(idx));
    endtask

    // run-length encode one line, first run in the low field
    task automatic push_line(input logic [max_dim-1:0] line, input int len,
                             input logic is_col, input int idx);
        logic [clue_w-1:0] word;
        int                runs;
        int                run;
        word = '0;
        runs = 0;
        run  = 0;
        for (int i = 0; i < len; i++) begin
            if (line[i]) begin
                run++;
            end else if (run > 0) begin
                word[runs * run_w +: run_w] = run_w'(run);
                runs++;
                run = 0;
            end
        end
        if (run > 0) begin  // run touching the line end
            word[runs * run_w +: run_w] = run_w'(run);
            runs++;
        end
        push_expected(word, runs, is_col, idx);
    endtask

    task automatic model_frame();
        logic [max_dim-1:0] line;
        for (int r = 0; r < grid_h; r++) begin
            line = '0;
            for (int c = 0; c < grid_w; c++) line[c] = model_grid[r][c];
            push_line(line, grid_w, 1'b0, r);
        end
        for (int c = 0; c < grid_w; c++) begin
            line = '0;
            for (int r = 0; r < grid_h; r++) line[r] = model_grid[r][c];
            push_line(line, grid_h, 1'b1, c);
        end
    endtask

    task automatic build_frames();
        logic [15:0]       r;
        pixel_t            p;
        logic [clue_w-1:0] word;
        for (int f = 0; f < frames; f++) begin
            for (int row = 0; row < grid_h; row++) begin
                for (int col = 0; col < grid_w; col++) begin
                    if (f == 0) begin
                        p = pixel_t'(12'hfff);  // every channel at 15
                    end else if (f == 1) begin
                        p = pixel_t'(12'h000);
                    end else begin
                        draw_bits(12, r);
                        p = pixel_t'(r[11:0]);
                    end
                    pix_mem[f * cells + row * grid_w + col] = p;
                    model_grid[row][col] = is_dark(p);
                end
            end
            if (f == 0) begin
                // nothing filled, all clues empty
                for (int i = 0; i < grid_h; i++) push_expected('0, 0, 1'b0, i);
                for (int i = 0; i < grid_w; i++) push_expected('0, 0, 1'b1, i);
            end else if (f == 1) begin
                // one full-length run per line
                word = '0;
                word[run_w-1:0] = run_w'(grid_w);
                for (int i = 0; i < grid_h; i++) push_expected(word, 1, 1'b0, i);
                word[run_w-1:0] = run_w'(grid_h);
                for (int i = 0; i < grid_w; i++) push_expected(word, 1, 1'b1, i);
            end else begin
                model_frame();
            end
        end
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_clue(input logic [clue_w-1:0] got_data,
                                input logic [clue_w-1:0] exp_data,
                                input logic [runs_bits-1:0] got_runs,
                                input logic [runs_bits-1:0] exp_runs);
        if (got_data !== exp_data) begin
            $display("FAIL clue_data got %h expected %h", got_data, exp_data);
            stop_run();
        end else if (got_runs !== exp_runs) begin
            $display("FAIL clue_runs got %h expected %h", got_runs, exp_runs);
            stop_run();
        end
    endtask

    task automatic compare_line(input logic got_col, input logic exp_col,
                                input logic [index_bits-1:0] got_idx,
                                input logic [index_bits-1:0] exp_idx);
        if (got_col !== exp_col) begin
            $display("FAIL clue_is_column got %h expected %h", got_col, exp_col);
            stop_run();
        end else if (got_idx !== exp_idx) begin
            $display("FAIL clue_index got %h expected %h", got_idx, exp_idx);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // handshake drivers, called on falling edges
    ////////////////////////////////////////

    task automatic drive_pixel();
        logic [15:0] r;
        if (!pixel_valid || pix_taken) begin
            if (pix_idx < total_cells) begin
                draw_bits(2, r);
                if (r[1:0] == 2'b00) begin
                    pixel_valid = 1'b0;  // gap, one cycle in four
                end else begin
                    pixel_valid = 1'b1;
                    pixel_data  = pix_mem[pix_idx];
                end
            end else begin
                pixel_valid = 1'b0;
            end
        end
        // ready does not depend on valid, so this predicts the next edge
        pix_taken = pixel_valid && pixel_ready;
        if (pix_taken) pix_idx++;
    endtask

    task automatic take_clue();
        logic [15:0]           r;
        logic [clue_w-1:0]     exp_data;
        logic [runs_bits-1:0]  exp_runs;
        logic                  exp_col;
        logic [index_bits-1:0] exp_idx;
        draw_bits(2, r);
        clue_ready = (r[1:0] != 2'b00);  // back-pressure one cycle in four
        if (clue_valid && clue_ready) begin
            if (exp_data_q.size() == 0) begin
                $display("a clue arrived after all expected clues were taken");
                stop_run();
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_runs = exp_runs_q.pop_front();
                exp_col  = exp_col_q.pop_front();
                exp_idx  = exp_idx_q.pop_front();
                compare_line(clue_is_column, exp_col, clue_index, exp_idx);
                compare_clue(clue_data, exp_data, clue_runs, exp_runs);
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        pixel_valid = 1'b0;
        pixel_data  = pixel_t'(12'h000);
        clue_ready  = 1'b0;
        build_frames();

        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(negedge clk_65mhz);
        check_flag("clue_valid", clue_valid, 1'b0);
        check_flag("pixel_ready", pixel_ready, 1'b1);

        while (exp_data_q.size() > 0 || pix_idx < total_cells) begin
            drive_pixel();
            take_clue();
            @(negedge clk_65mhz);
        end

        pixel_valid = 1'b0;
        clue_ready  = 1'b0;
        repeat (4) @(negedge clk_65mhz);
        check_flag("clue_valid", clue_valid, 1'b0);  // nothing left over

        $display("NO ERRORS");
        $finish;
    end

    // watchdog
    always @(posedge clk_65mhz) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("timeout, run did not finish within %0d cycles", timeout_limit);
                stop_run();
            end
        end
    end

endmodule

`default_nettype wire

// File: files.f
src/nonogram_pkg.sv
src/cell_binarizer.sv
src/grid_frame_buffer.sv
src/clue_encoder.sv
src/nonogram_clue_top.sv
testbench/tb_clock_gen.sv
testbench/nonogram_clue_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the nonogram clue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module nonogram_clue_tb -f files.f -o nonogram_clue_sim

status=0
./obj_dir/nonogram_clue_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "NO ERRORS" sim.log; then
    echo "simulation did not finish cleanly, see sim.log"
    exit 1
fi
echo "simulation passed"
